//--- bfp_pkg.sv
`default_nettype none

package bfp_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // block format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int BLOCK_SIZE  = 4;
  localparam int MANT_WIDTH  = 8;
  // mantissa is s1.6
  localparam int MANT_FRAC   = 6;
  localparam int EXP_WIDTH   = 8;
  localparam int EXP_BIAS    = 127;
  localparam int OUT_WIDTH   = 16;
  localparam int SHIFT_WIDTH = 6;

  // worst case left shift is OUT_WIDTH - 1
  localparam int SHIFT_DATA_WIDTH = MANT_WIDTH + OUT_WIDTH - 1;

  localparam logic signed [SHIFT_WIDTH-1:0] SHIFT_MAX = (2 ** (SHIFT_WIDTH - 1)) - 1;
  localparam logic signed [SHIFT_WIDTH-1:0] SHIFT_MIN = -(2 ** (SHIFT_WIDTH - 1));

  localparam logic signed [OUT_WIDTH-1:0] OUT_MAX = (2 ** (OUT_WIDTH - 1)) - 1;
  localparam logic signed [OUT_WIDTH-1:0] OUT_MIN = -(2 ** (OUT_WIDTH - 1));

  // fraction bits of each output format
  localparam int FRAC_Q8_8  = 8;
  localparam int FRAC_Q4_12 = 12;

  typedef enum logic [0:0] {
    FMT_Q8_8  = 1'b0,
    FMT_Q4_12 = 1'b1
  } fmt_e;

  typedef logic signed [MANT_WIDTH-1:0] mant_t;
  typedef logic signed [OUT_WIDTH-1:0]  word_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pipeline payloads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    fmt_e                        fmt;
    logic [EXP_WIDTH-1:0]        exp;
    mant_t [BLOCK_SIZE-1:0]      mant;
  } bfp_block_t;

  typedef struct packed {
    logic signed [SHIFT_WIDTH-1:0] shift;
    mant_t [BLOCK_SIZE-1:0]        mant;
  } shift_req_t;

  typedef struct packed {
    word_t [BLOCK_SIZE-1:0] data;
  } fixed_block_t;

  function automatic int fmt_frac_bits(fmt_e fmt);
    case (fmt)
      FMT_Q4_12: return FRAC_Q4_12;
      default:   return FRAC_Q8_8;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- bfp_shift_calc.sv
`timescale 1ns/1ps
`default_nettype none

module bfp_shift_calc
  import bfp_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       arst_n,

  input  wire logic       in_valid,
  output logic            in_ready,
  input  wire bfp_block_t in_block,

  output logic            out_valid,
  input  wire logic       out_ready,
  output shift_req_t      out_req
);

  // bias + frac - fmt_frac - exp spans -134 .. 125
  localparam int CALC_WIDTH = EXP_WIDTH + 2;

  logic signed [CALC_WIDTH-1:0]  shift_wide;
  logic signed [CALC_WIDTH-1:0]  shift_base;
  logic signed [SHIFT_WIDTH-1:0] shift_sat;
  shift_req_t                    req_next;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shift amount
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign shift_base = CALC_WIDTH'(EXP_BIAS + MANT_FRAC - fmt_frac_bits(in_block.fmt));
  assign shift_wide = shift_base - $signed({2'b00, in_block.exp});

  // clip into the shifter range
  always_comb begin
    if (shift_wide > SHIFT_MAX) begin
      shift_sat = SHIFT_MAX;
    end else if (shift_wide < SHIFT_MIN) begin
      shift_sat = SHIFT_MIN;
    end else begin
      shift_sat = shift_wide[SHIFT_WIDTH-1:0];
    end
  end

  always_comb begin
    req_next       = '0;
    req_next.shift = shift_sat;
    req_next.mant  = in_block.mant;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one slot output register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // free when empty or drained this cycle
  assign in_ready = ~out_valid | out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_req <= req_next;
    end
  end

endmodule

`default_nettype wire

//--- bfp_shift_stage.sv
`timescale 1ns/1ps
`default_nettype none

module bfp_shift_stage
  import bfp_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       arst_n,

  input  wire logic       in_valid,
  output logic            in_ready,
  input  wire shift_req_t in_req,

  output logic            out_valid,
  input  wire logic       out_ready,
  output fixed_block_t    out_block
);

  fixed_block_t shifted;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // block shifter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  block_saturating_shift i_shift (
    .req  (in_req),
    .data (shifted)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // ready follows out_ready combinationally
  assign in_ready = ~out_valid | out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // held while stalled
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_block <= shifted;
    end
  end

endmodule

`default_nettype wire

//--- bfp_to_fixed.sv
`timescale 1ns/1ps
`default_nettype none

module bfp_to_fixed
  import bfp_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       arst_n,

  // block floating point in
  input  wire logic       in_valid,
  output logic            in_ready,
  input  wire bfp_block_t in_block,

  // fixed point out
  output logic            out_valid,
  input  wire logic       out_ready,
  output fixed_block_t    out_block
);

  logic       s1_valid;
  logic       s1_ready;
  shift_req_t s1_req;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage 1, shift amount
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  bfp_shift_calc i_calc (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_block  (in_block),
    .out_valid (s1_valid),
    .out_ready (s1_ready),
    .out_req   (s1_req)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage 2, block shift
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  bfp_shift_stage i_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (s1_valid),
    .in_ready  (s1_ready),
    .in_req    (s1_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_block (out_block)
  );

endmodule

`default_nettype wire

//--- bfp_to_fixed_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module bfp_to_fixed_assertions
  import bfp_pkg::*;
(
  input wire logic         clk,
  input wire logic         arst_n,
  input wire logic         in_valid,
  input wire logic         in_ready,
  input wire bfp_block_t   in_block,
  input wire logic         s1_valid,
  input wire logic         s1_ready,
  input wire shift_req_t   s1_req,
  input wire logic         out_valid,
  input wire logic         out_ready,
  input wire fixed_block_t out_block
);

  int unsigned assert_failures = 0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // valid and payload hold until taken
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_in_hold: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_block))
    else begin
      assert_failures++;
      $error("input valid or block changed while stalled");
    end

  a_link_hold: assert property (@(posedge clk) disable iff (!arst_n)
    s1_valid && !s1_ready |=> s1_valid && $stable(s1_req))
    else begin
      assert_failures++;
      $error("stage 1 valid or request changed while stalled");
    end

  a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_block))
    else begin
      assert_failures++;
      $error("output valid or block changed while stalled");
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reset values
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid && !s1_valid)
    else begin
      assert_failures++;
      $error("valid high during reset");
    end

  a_after_reset: assert property (@(posedge clk)
    $rose(arst_n) |-> !out_valid && !s1_valid && in_ready)
    else begin
      assert_failures++;
      $error("wrong handshake state right after reset");
    end

endmodule

bind bfp_to_fixed bfp_to_fixed_assertions i_assertions (.*);

`default_nettype wire

//--- block_saturating_shift.sv
`timescale 1ns/1ps
`default_nettype none

module block_saturating_shift
  import bfp_pkg::*;
(
  input  wire shift_req_t req,
  output fixed_block_t    data
);

  localparam int AMT_WIDTH = $clog2(OUT_WIDTH);

  logic                   shift_neg;
  logic [SHIFT_WIDTH-1:0] shift_mag;
  logic [AMT_WIDTH-1:0]   shift_amt;
  logic                   left_overflow;

  logic signed [SHIFT_DATA_WIDTH-1:0] cand    [BLOCK_SIZE];
  word_t                              clamped [BLOCK_SIZE];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shift decode, shared by all lanes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign shift_neg = req.shift[SHIFT_WIDTH-1];

  // -32 maps to 32 as unsigned, which is still correct
  assign shift_mag = shift_neg ? (~req.shift + 1'b1) : req.shift;

  // right shifts past 15 only leave sign bits anyway
  always_comb begin
    if (shift_mag > SHIFT_WIDTH'(OUT_WIDTH - 1)) begin
      shift_amt = AMT_WIDTH'(OUT_WIDTH - 1);
    end else begin
      shift_amt = shift_mag[AMT_WIDTH-1:0];
    end
  end

  // left shift by 16 or more overflows any nonzero mantissa
  assign left_overflow = shift_neg && (shift_mag >= SHIFT_WIDTH'(OUT_WIDTH));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per mantissa lanes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_lane
    logic signed [SHIFT_DATA_WIDTH-1:0] wide;
    word_t                              lane_out;

    // sign extend before shifting
    assign wide = SHIFT_DATA_WIDTH'($signed(req.mant[i]));

    // >>> truncates toward minus infinity
    assign cand[i] = shift_neg ? (wide <<< shift_amt) : (wide >>> shift_amt);

    signed_clamp i_clamp (
      .in_data  (cand[i]),
      .out_data (clamped[i])
    );

    always_comb begin
      if (req.mant[i] == '0) begin
        lane_out = '0;
      end else if (left_overflow) begin
        // saturate by sign of mantissa
        lane_out = req.mant[i][MANT_WIDTH-1] ? OUT_MIN : OUT_MAX;
      end else begin
        lane_out = clamped[i];
      end
    end

    assign data.data[i] = lane_out;
  end

endmodule

`default_nettype wire

//--- compile.f
bfp_pkg.sv
signed_clamp.sv
block_saturating_shift.sv
bfp_shift_calc.sv
bfp_shift_stage.sv
bfp_to_fixed.sv
bfp_to_fixed_assertions.sv
tb_bfp_to_fixed.sv

//--- signed_clamp.sv
`timescale 1ns/1ps
`default_nettype none

module signed_clamp
  import bfp_pkg::*;
(
  input  wire logic signed [SHIFT_DATA_WIDTH-1:0] in_data,
  output logic signed [OUT_WIDTH-1:0]             out_data
);

  logic too_big;
  logic too_small;

  // limits get sign extended to the input width
  assign too_big   = (in_data > OUT_MAX);
  assign too_small = (in_data < OUT_MIN);

  always_comb begin
    if (too_big) begin
      out_data = OUT_MAX;
    end else if (too_small) begin
      out_data = OUT_MIN;
    end else begin
      // in range, upper bits are pure sign
      out_data = in_data[OUT_WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

//--- tb_bfp_to_fixed.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bfp_to_fixed
  import bfp_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 1000;
  localparam int NUM_RANDOM     = 200;

  logic         clk = 1'b0;
  logic         arst_n;
  logic         in_valid;
  logic         in_ready;
  bfp_block_t   in_block;
  logic         out_valid;
  logic         out_ready;
  fixed_block_t out_block;

  fixed_block_t exp_q[$];
  bfp_block_t   rand_blocks[NUM_RANDOM];
  int           seed = 85;
  int           accepted;
  int           delivered;
  logic         ready_toggle;
  int           extremes[6] = '{0, 1, 127, 128, 254, 255};

  bfp_to_fixed i_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_block  (in_block),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_block (out_block)
  );

  always #20 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checking helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("CHECK FAILED at %0t: %s, got %0d, expected %0d",
               $time, what, actual, expected);
      abort_run();
    end
  endtask

  // expected block straight from the conversion rule
  function automatic fixed_block_t to_fixed_ref(input bfp_block_t blk);
    fixed_block_t res;
    int e;
    int shift;
    int amt;
    int m;
    int v;
    e = blk.exp;
    shift = EXP_BIAS + MANT_FRAC - fmt_frac_bits(blk.fmt) - e;
    if (shift > 31) begin
      shift = 31;
    end else if (shift < -32) begin
      shift = -32;
    end
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      m = $signed(blk.mant[i]);
      if (m == 0) begin
        v = 0;
      end else if (shift >= 0) begin
        amt = (shift > 15) ? 15 : shift;
        v = m / (1 << amt);
        // division rounds toward zero, step down for negative remainders
        if (m < 0 && v * (1 << amt) != m) begin
          v = v - 1;
        end
      end else if (-shift >= 16) begin
        v = (m > 0) ? 32767 : -32768;
      end else begin
        v = m * (1 << -shift);
        if (v > 32767) begin
          v = 32767;
        end else if (v < -32768) begin
          v = -32768;
        end
      end
      res.data[i] = v[OUT_WIDTH-1:0];
    end
    return res;
  endfunction

  function automatic bfp_block_t make_block(input fmt_e fmt, input int e,
                                            input int m0, input int m1,
                                            input int m2, input int m3);
    bfp_block_t blk;
    blk.fmt     = fmt;
    blk.exp     = e[EXP_WIDTH-1:0];
    blk.mant[0] = m0[MANT_WIDTH-1:0];
    blk.mant[1] = m1[MANT_WIDTH-1:0];
    blk.mant[2] = m2[MANT_WIDTH-1:0];
    blk.mant[3] = m3[MANT_WIDTH-1:0];
    return blk;
  endfunction

  // exponent near the bias most of the time, anywhere otherwise
  function automatic bfp_block_t random_block();
    bfp_block_t  blk;
    logic [31:0] r;
    logic [31:0] m;
    r = $random(seed);
    m = $random(seed);
    blk.fmt  = fmt_e'(r[0]);
    blk.exp  = r[1] ? r[15:8] : (8'd104 + {3'b000, r[6:2]});
    blk.mant = m;
    return blk;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // driver tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic send_block(input bfp_block_t blk);
    int cycles;
    @(negedge clk);
    in_valid = 1'b1;
    in_block = blk;
    exp_q.push_back(to_fixed_ref(blk));
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!in_ready && cycles < TIMEOUT_CYCLES);
    if (!in_ready) begin
      $display("ERROR at %0t: input block was never accepted", $time);
      abort_run();
    end
  endtask

  task automatic drop_valid();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR at %0t: expected output blocks did not arrive", $time);
      abort_run();
    end
  endtask

  // single block, count cycles until out_valid shows up
  task automatic check_latency(input bfp_block_t blk);
    int cycles;
    send_block(blk);
    cycles = 0;
    do begin
      @(negedge clk);
      in_valid = 1'b0;
      cycles++;
    end while (!out_valid && cycles < TIMEOUT_CYCLES);
    if (!out_valid) begin
      $display("ERROR at %0t: output block did not arrive", $time);
      abort_run();
    end
    check_value(cycles, 2, "latency from accept to out_valid");
  endtask

  // random back-pressure
  always @(negedge clk) begin
    logic [31:0] r;
    if (ready_toggle) begin
      r = $random(seed);
      out_ready = r[0];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // scoreboard
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin
    fixed_block_t expected;
    if (arst_n) begin
      check_value(i_dut.i_assertions.assert_failures, 0, "concurrent assertion failures");
      // stall only with both slots occupied
      if (!in_ready) begin
        check_value(accepted - delivered, 2, "in_ready low with a free slot");
      end
      if (in_valid && in_ready) begin
        accepted++;
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("ERROR at %0t: output block arrived with nothing expected", $time);
          abort_run();
        end else begin
          expected = exp_q.pop_front();
          for (int i = 0; i < BLOCK_SIZE; i++) begin
            check_value(out_block.data[i], expected.data[i], $sformatf("word %0d", i));
          end
          delivered++;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    in_block     = '0;
    out_ready    = 1'b0;
    ready_toggle = 1'b0;
    accepted     = 0;
    delivered    = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    check_value(in_ready, 1, "in_ready after reset");
    check_value(out_valid, 0, "out_valid after reset");
    check_value(i_dut.s1_valid, 0, "stage 1 valid after reset");
    out_ready = 1'b1;
    check_latency(make_block(FMT_Q8_8, 120, 64, -64, 1, -1));
    wait_drain();

    // right shifts around the bias
    for (int e = 100; e <= 125; e++) begin
      send_block(make_block(FMT_Q8_8, e, 127, -128, 37, -37));
      send_block(make_block(FMT_Q8_8, e, 1, -1, 64, -5));
    end
    // left shifts, clamping and full saturation
    for (int e = 118; e <= 145; e++) begin
      send_block(make_block(FMT_Q4_12, e, 127, -128, 3, -3));
      send_block(make_block(FMT_Q4_12, e, 1, -1, 100, -100));
    end
    // zero mantissas, exponent extremes
    foreach (extremes[k]) begin
      send_block(make_block(FMT_Q8_8, extremes[k], 0, 0, 0, 0));
      send_block(make_block(FMT_Q4_12, extremes[k], 0, 0, 0, 0));
      send_block(make_block(FMT_Q8_8, extremes[k], 0, 5, 0, -5));
      send_block(make_block(FMT_Q4_12, extremes[k], -7, 0, 9, 0));
    end
    // formats mixed block by block
    for (int i = 0; i < 40; i++) begin
      send_block(random_block());
    end
    drop_valid();
    wait_drain();

    for (int i = 0; i < NUM_RANDOM; i++) begin
      rand_blocks[i] = random_block();
    end
    @(posedge clk);
    ready_toggle = 1'b1;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      send_block(rand_blocks[i]);
    end
    drop_valid();
    @(posedge clk);
    ready_toggle = 1'b0;
    @(negedge clk);
    out_ready = 1'b1;
    wait_drain();

    // nothing left in flight once every block is out
    check_value(out_valid, 0, "out_valid after the last block");
    check_value(i_dut.s1_valid, 0, "stage 1 valid after the last block");
    check_value(i_dut.i_assertions.assert_failures, 0, "concurrent assertion failures");
    if (exp_q.size() != 0) begin
      $display("ERROR: %0d blocks still expected at the end", exp_q.size());
      abort_run();
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
